// ==== source/dll_tx_pkg.sv ====
//////////////////////////////////////////////////
// shared widths and limits for the DLL transmit path
// one frame in flight; LCRC and framing not covered
// data_width must be a multiple of 8
//////////////////////////////////////////////////

package dll_tx_pkg;

  // link beat width
  localparam int data_width = 32;

  // one keep bit per byte lane
  localparam int keep_width = data_width / 8;

  // PCIe sequence numbers are 12 bits, wrap at 4096
  localparam int seq_width = 12;

  // max payload in bytes for this link
  localparam int max_payload_size = 256;

  // 3DW or 4DW TLP header, worst case 4 beats
  localparam int max_hdr_beats = 4;

  // longest frame in beats, header plus payload
  localparam int max_pkt_beats = (max_payload_size / keep_width) + max_hdr_beats;

  // buffer address bits
  localparam int ptr_width = $clog2(max_pkt_beats);

  // cycles after the last beat before a replay is forced
  localparam int replay_timeout = 64;

  // replay counter bits
  localparam int timer_width = $clog2(replay_timeout + 1);

endpackage : dll_tx_pkg

// ==== source/tlp_seq_stamper.sv ====
//////////////////////////////////////////////////
// tags every beat of a frame with its sequence number
// zero latency, ready passes straight back upstream
// sequence wraps modulo 4096, starts at 0 after reset
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tlp_seq_stamper (
  input  logic                            clk_i,
  input  logic                            rst_i,

  // frames from the transaction layer
  input  logic [dll_tx_pkg::data_width-1:0] s_tdata,
  input  logic [dll_tx_pkg::keep_width-1:0] s_tkeep,
  input  logic                            s_tvalid,
  input  logic                            s_tlast,
  output logic                            s_tready,

  // stamped frames toward the retry buffer
  output logic [dll_tx_pkg::data_width-1:0] st_tdata,
  output logic [dll_tx_pkg::keep_width-1:0] st_tkeep,
  output logic                            st_tvalid,
  output logic                            st_tlast,
  output logic [dll_tx_pkg::seq_width-1:0]  st_tseq,
  input  logic                            st_tready
);

  import dll_tx_pkg::*;

  // sequence number of the frame now passing through
  logic [seq_width-1:0] seq_r;
  // beat index inside the current frame
  logic [ptr_width-1:0] beat_cnt;
  // beat handshake
  logic                 beat_acc;

  assign beat_acc = s_tvalid && st_tready;

  // pure pass-through path, no storage
  assign st_tdata  = s_tdata;
  assign st_tkeep  = s_tkeep;
  assign st_tvalid = s_tvalid;
  assign st_tlast  = s_tlast;
  assign st_tseq   = seq_r;
  assign s_tready  = st_tready;

  // next sequence, moves on when tlast goes through
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      seq_r <= '0;
    end else if (beat_acc && s_tlast) begin
      // natural wrap at 2**seq_width
      seq_r <= seq_r + 1'b1;
    end
  end

  // beat counter for the frame length check
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_cnt <= '0;
    end else if (beat_acc) begin
      if (s_tlast) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // frame must fit the retry buffer
  a_frame_len : assert property (
    @(posedge clk_i) disable iff (rst_i)
    beat_acc |-> (beat_cnt < ptr_width'(max_pkt_beats))
  );

  // upstream keeps valid up until the beat is taken
  a_valid_hold : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (s_tvalid && !s_tready) |=> s_tvalid
  );

endmodule : tlp_seq_stamper

// ==== source/axis_retry_fifo.sv ====
//////////////////////////////////////////////////
// single-frame retry buffer, store and forward
// write side stalls while a frame is held
// frame stays until frame_release, replay rewinds it
// replay is only legal once the frame has been sent
//////////////////////////////////////////////////

`timescale 1ns/1ps

module axis_retry_fifo (
  input  logic                            clk_i,
  input  logic                            rst_i,

  // stamped frames in
  input  logic [dll_tx_pkg::data_width-1:0] st_tdata,
  input  logic [dll_tx_pkg::keep_width-1:0] st_tkeep,
  input  logic                            st_tvalid,
  input  logic                            st_tlast,
  input  logic [dll_tx_pkg::seq_width-1:0]  st_tseq,
  output logic                            st_tready,

  // held frame out to the link sender
  output logic [dll_tx_pkg::data_width-1:0] rb_tdata,
  output logic [dll_tx_pkg::keep_width-1:0] rb_tkeep,
  output logic                            rb_tvalid,
  output logic                            rb_tlast,
  output logic [dll_tx_pkg::seq_width-1:0]  rb_tseq,
  input  logic                            rb_tready,

  // control pulses from the sender
  input  logic                            frame_release,
  input  logic                            replay
);

  import dll_tx_pkg::*;

  // frame storage, one entry per beat
  logic [data_width-1:0] mem_data [max_pkt_beats];
  logic [keep_width-1:0] mem_keep [max_pkt_beats];
  logic                  mem_last [max_pkt_beats];
  // sequence of the stored frame
  logic [seq_width-1:0]  frame_seq;

  logic [ptr_width-1:0]  wr_ptr;
  logic [ptr_width-1:0]  rd_ptr;
  // a complete frame sits in memory
  logic                  frame_held;
  // frame is being streamed out
  logic                  rd_active;

  logic                  wr_acc;
  logic                  rd_acc;

  // accept only while empty
  assign st_tready = !frame_held;
  assign wr_acc    = st_tvalid && st_tready;
  assign rd_acc    = rd_active && rb_tready;

  // read side straight from memory
  assign rb_tvalid = rd_active;
  assign rb_tdata  = mem_data[rd_ptr];
  assign rb_tkeep  = mem_keep[rd_ptr];
  assign rb_tlast  = mem_last[rd_ptr];
  assign rb_tseq   = frame_seq;

  // memory and seq capture
  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      mem_data[wr_ptr] <= st_tdata;
      mem_keep[wr_ptr] <= st_tkeep;
      mem_last[wr_ptr] <= st_tlast;
      // same value on every beat of the frame
      frame_seq        <= st_tseq;
    end
  end

  // write pointer, back to 0 at frame end
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
    end else if (wr_acc) begin
      if (st_tlast) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // held flag
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      frame_held <= 1'b0;
    end else if (wr_acc && st_tlast) begin
      frame_held <= 1'b1;
    end else if (frame_release) begin
      // ACK seen, slot free again
      frame_held <= 1'b0;
    end
  end

  // read pointer and active flag
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr    <= '0;
      rd_active <= 1'b0;
    end else if (wr_acc && st_tlast) begin
      // first transmission starts next cycle
      rd_ptr    <= '0;
      rd_active <= 1'b1;
    end else if (replay) begin
      // rewind and send it all again
      rd_ptr    <= '0;
      rd_active <= 1'b1;
    end else if (rd_acc) begin
      if (rb_tlast) begin
        rd_ptr    <= '0;
        rd_active <= 1'b0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // held frame never overwritten while it still streams out
  a_no_write_held : assert property (
    @(posedge clk_i) disable iff (rst_i)
    wr_acc |-> !rd_active
  );

  // sender only replays a frame that is fully out
  a_no_replay_reading : assert property (
    @(posedge clk_i) disable iff (rst_i)
    replay |-> (frame_held && !rd_active)
  );

endmodule : axis_retry_fifo

// ==== source/dll_tx_sender.sv ====
//////////////////////////////////////////////////
// drives buffer beats onto the link, zero latency
// ACK/NAK honoured only while waiting after a frame
// replay on NAK or after replay_timeout idle cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dll_tx_sender (
  input  logic                            clk_i,
  input  logic                            rst_i,

  // from the retry buffer
  input  logic [dll_tx_pkg::data_width-1:0] rb_tdata,
  input  logic [dll_tx_pkg::keep_width-1:0] rb_tkeep,
  input  logic                            rb_tvalid,
  input  logic                            rb_tlast,
  input  logic [dll_tx_pkg::seq_width-1:0]  rb_tseq,
  output logic                            rb_tready,

  // buffer control pulses
  output logic                            frame_release,
  output logic                            replay,

  // physical side
  output logic [dll_tx_pkg::data_width-1:0] link_tdata,
  output logic [dll_tx_pkg::keep_width-1:0] link_tkeep,
  output logic                            link_tvalid,
  output logic                            link_tlast,
  output logic [dll_tx_pkg::seq_width-1:0]  link_tseq,
  input  logic                            link_tready,

  // acknowledgements from the receive side
  input  logic                            dllp_valid,
  input  logic                            dllp_nak,
  input  logic [dll_tx_pkg::seq_width-1:0]  dllp_seq
);

  import dll_tx_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_send,
    st_wait
  } state_t;

  state_t                state;
  // seq of the frame awaiting ACK
  logic [seq_width-1:0]  sent_seq;
  // cycles spent waiting
  logic [timer_width-1:0] timer;

  logic                  last_beat;
  logic                  ack_ok;
  logic                  nak_seen;
  logic                  timed_out;

  // straight wires to the link, back-pressure included
  assign link_tdata  = rb_tdata;
  assign link_tkeep  = rb_tkeep;
  assign link_tvalid = rb_tvalid;
  assign link_tlast  = rb_tlast;
  assign link_tseq   = rb_tseq;
  assign rb_tready   = link_tready;

  assign last_beat = rb_tvalid && link_tready && rb_tlast;
  // wrong-seq ACKs fall through and are dropped
  assign ack_ok    = dllp_valid && !dllp_nak && (dllp_seq == sent_seq);
  assign nak_seen  = dllp_valid && dllp_nak;
  assign timed_out = (timer == timer_width'(replay_timeout - 1));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state         <= st_idle;
      frame_release <= 1'b0;
      replay        <= 1'b0;
      timer         <= '0;
    end else begin
      // pulses last one cycle
      frame_release <= 1'b0;
      replay        <= 1'b0;
      case (state)
        st_idle: begin
          if (last_beat) begin
            state <= st_wait;
            timer <= '0;
          end else if (rb_tvalid) begin
            state <= st_send;
          end
        end
        st_send: begin
          if (last_beat) begin
            state <= st_wait;
            timer <= '0;
          end
        end
        st_wait: begin
          timer <= timer + 1'b1;
          if (ack_ok) begin
            frame_release <= 1'b1;
            state         <= st_idle;
          end else if (nak_seen || timed_out) begin
            // buffer restarts the frame the cycle after the pulse
            replay <= 1'b1;
            state  <= st_send;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // remember what went out last
  always_ff @(posedge clk_i) begin
    if (last_beat) begin
      sent_seq <= rb_tseq;
    end
  end

  // release and replay only while the link is quiet
  a_pulse_quiet : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (frame_release || replay) |-> !link_tvalid
  );

  // buffer must answer a replay with data right away
  a_replay_restart : assert property (
    @(posedge clk_i) disable iff (rst_i)
    replay |=> link_tvalid
  );

endmodule : dll_tx_sender

// ==== source/dll_tx_top.sv ====
//////////////////////////////////////////////////
// DLL transmit retry path, stamper to buffer to link
// one outstanding frame, write side stalls until ACK
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dll_tx_top (
  input  logic                            clk_i,
  input  logic                            rst_i,

  // transaction layer side
  input  logic [dll_tx_pkg::data_width-1:0] s_tdata,
  input  logic [dll_tx_pkg::keep_width-1:0] s_tkeep,
  input  logic                            s_tvalid,
  input  logic                            s_tlast,
  output logic                            s_tready,

  // link side
  output logic [dll_tx_pkg::data_width-1:0] link_tdata,
  output logic [dll_tx_pkg::keep_width-1:0] link_tkeep,
  output logic                            link_tvalid,
  output logic                            link_tlast,
  output logic [dll_tx_pkg::seq_width-1:0]  link_tseq,
  input  logic                            link_tready,

  // ACK/NAK DLLP strobe
  input  logic                            dllp_valid,
  input  logic                            dllp_nak,
  input  logic [dll_tx_pkg::seq_width-1:0]  dllp_seq
);

  import dll_tx_pkg::*;

  // stamper to buffer
  logic [data_width-1:0] st_tdata;
  logic [keep_width-1:0] st_tkeep;
  logic                  st_tvalid;
  logic                  st_tlast;
  logic [seq_width-1:0]  st_tseq;
  logic                  st_tready;

  // buffer to sender
  logic [data_width-1:0] rb_tdata;
  logic [keep_width-1:0] rb_tkeep;
  logic                  rb_tvalid;
  logic                  rb_tlast;
  logic [seq_width-1:0]  rb_tseq;
  logic                  rb_tready;

  // sender control back to buffer
  logic                  frame_release;
  logic                  replay;

  tlp_seq_stamper i_stamper (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s_tdata   (s_tdata),
    .s_tkeep   (s_tkeep),
    .s_tvalid  (s_tvalid),
    .s_tlast   (s_tlast),
    .s_tready  (s_tready),
    .st_tdata  (st_tdata),
    .st_tkeep  (st_tkeep),
    .st_tvalid (st_tvalid),
    .st_tlast  (st_tlast),
    .st_tseq   (st_tseq),
    .st_tready (st_tready)
  );

  axis_retry_fifo i_retry_fifo (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .st_tdata      (st_tdata),
    .st_tkeep      (st_tkeep),
    .st_tvalid     (st_tvalid),
    .st_tlast      (st_tlast),
    .st_tseq       (st_tseq),
    .st_tready     (st_tready),
    .rb_tdata      (rb_tdata),
    .rb_tkeep      (rb_tkeep),
    .rb_tvalid     (rb_tvalid),
    .rb_tlast      (rb_tlast),
    .rb_tseq       (rb_tseq),
    .rb_tready     (rb_tready),
    .frame_release (frame_release),
    .replay        (replay)
  );

  dll_tx_sender i_sender (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .rb_tdata      (rb_tdata),
    .rb_tkeep      (rb_tkeep),
    .rb_tvalid     (rb_tvalid),
    .rb_tlast      (rb_tlast),
    .rb_tseq       (rb_tseq),
    .rb_tready     (rb_tready),
    .frame_release (frame_release),
    .replay        (replay),
    .link_tdata    (link_tdata),
    .link_tkeep    (link_tkeep),
    .link_tvalid   (link_tvalid),
    .link_tlast    (link_tlast),
    .link_tseq     (link_tseq),
    .link_tready   (link_tready),
    .dllp_valid    (dllp_valid),
    .dllp_nak      (dllp_nak),
    .dllp_seq      (dllp_seq)
  );

endmodule : dll_tx_top

// ==== verification/tb_clk_gen.sv ====
//////////////////////////////////////////////////
// free-running testbench clock, reset high at start
// reset drops on a rising edge, synchronous to clk_i
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 16
) (
  output logic clk_i,
  output logic rst_i
);

  initial begin
    clk_i = 1'b0;
    forever #(period_ns / 2) clk_i = ~clk_i;
  end

  // hold reset for a fixed number of edges
  initial begin
    rst_i = 1'b1;
    repeat (reset_cycles) @(posedge clk_i);
    rst_i <= 1'b0;
  end

endmodule : tb_clk_gen

// ==== verification/tb_dll_tx.sv ====
//////////////////////////////////////////////////
// random frames checked against a one-frame model
// responder answers ACK, wrong ACK, NAK or silence
// fixed seed, every wait is bounded
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_dll_tx;

  import dll_tx_pkg::*;

  localparam int num_frames = 40;
  localparam int tx_limit   = 2000;

  logic                  clk_i;
  logic                  rst_i;
  logic [data_width-1:0] s_tdata;
  logic [keep_width-1:0] s_tkeep;
  logic                  s_tvalid;
  logic                  s_tlast;
  logic                  s_tready;
  logic [data_width-1:0] link_tdata;
  logic [keep_width-1:0] link_tkeep;
  logic                  link_tvalid;
  logic                  link_tlast;
  logic [seq_width-1:0]  link_tseq;
  logic                  link_tready;
  logic                  dllp_valid;
  logic                  dllp_nak;
  logic [seq_width-1:0]  dllp_seq;

  int seed = 41;
  // separate stream for back-pressure, also derived from 41
  int link_seed = 41 * 7;

  // the one frame the DUT may hold
  logic [data_width-1:0] frm_data [max_pkt_beats];
  logic [keep_width-1:0] frm_keep [max_pkt_beats];
  int                    frm_len;
  // sequence numbers of frames not yet released
  logic [seq_width-1:0]  seq_q[$];
  logic [seq_width-1:0]  next_seq;

  int    cyc;
  int    mon_idx;
  int    tx_count;
  int    last_cyc;
  int    last_gap;
  bit    hung;
  int    chk_cnt [1:6];
  int    err_cnt [1:6];
  string test_name [1:6];

  tb_clk_gen #(.period_ns(10), .reset_cycles(16)) i_clk_gen (
    .clk_i (clk_i),
    .rst_i (rst_i)
  );

  dll_tx_top i_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .s_tdata     (s_tdata),
    .s_tkeep     (s_tkeep),
    .s_tvalid    (s_tvalid),
    .s_tlast     (s_tlast),
    .s_tready    (s_tready),
    .link_tdata  (link_tdata),
    .link_tkeep  (link_tkeep),
    .link_tvalid (link_tvalid),
    .link_tlast  (link_tlast),
    .link_tseq   (link_tseq),
    .link_tready (link_tready),
    .dllp_valid  (dllp_valid),
    .dllp_nak    (dllp_nak),
    .dllp_seq    (dllp_seq)
  );

  function automatic int rand_below(int n);
    return {$random(seed)} % n;
  endfunction

  task automatic flag_error(int id, string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    err_cnt[id]++;
  endtask

  // link side stalls about one cycle in four
  always @(posedge clk_i) begin
    link_tready <= ({$random(link_seed)} % 4) != 0;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // link monitor, sampled mid-cycle where outputs are settled
  always @(negedge clk_i) begin
    if (!rst_i && link_tvalid && link_tready) begin
      chk_cnt[2]++;
      // distance from the previous last beat, used for replay timing
      if (mon_idx == 0) begin
        last_gap = cyc - last_cyc;
      end
      if (seq_q.size() == 0) begin
        flag_error(2, "link beat while no frame is outstanding");
      end else if (link_tseq !== seq_q[0]) begin
        flag_error(2, $sformatf("link_tseq %0d, expected %0d", link_tseq, seq_q[0]));
      end
      if (mon_idx >= frm_len) begin
        flag_error(2, $sformatf("beat %0d past frame length %0d", mon_idx, frm_len));
      end else begin
        if (link_tdata !== frm_data[mon_idx] || link_tkeep !== frm_keep[mon_idx]) begin
          flag_error(2, $sformatf("beat %0d data %h keep %h, expected %h %h", mon_idx,
                     link_tdata, link_tkeep, frm_data[mon_idx], frm_keep[mon_idx]));
        end
        if (link_tlast !== (mon_idx == frm_len - 1)) begin
          flag_error(2, $sformatf("beat %0d tlast %b", mon_idx, link_tlast));
        end
      end
      if (link_tlast) begin
        mon_idx  = 0;
        last_cyc = cyc;
        tx_count++;
      end else begin
        mon_idx++;
      end
    end
  end

  task automatic build_frame();
    int b;
    frm_len = 1 + rand_below(max_pkt_beats);
    for (b = 0; b < frm_len; b++) begin
      frm_data[b] = $random(seed);
      frm_keep[b] = $random(seed);
    end
  endtask

  // one beat per handshake, random idle cycles between beats
  task automatic drive_frame();
    int b;
    int t;
    b = 0;
    while (b < frm_len && !hung) begin
      if (rand_below(4) == 0) begin
        s_tvalid <= 1'b0;
        @(posedge clk_i);
      end else begin
        s_tdata  <= frm_data[b];
        s_tkeep  <= frm_keep[b];
        s_tlast  <= (b == frm_len - 1);
        s_tvalid <= 1'b1;
        @(posedge clk_i);
        t = 0;
        while (!s_tready && t < 100) begin
          @(posedge clk_i);
          t++;
        end
        if (!s_tready) begin
          $display("timeout: s_tready stuck low while driving a frame");
          hung = 1'b1;
        end else begin
          // tlast taken, sequence advances for the next frame
          if (b == frm_len - 1) begin
            seq_q.push_back(next_seq);
            next_seq = next_seq + 1'b1;
          end
          b++;
        end
      end
    end
    s_tvalid <= 1'b0;
  endtask

  // wait for the link to finish a transmission, optionally watching the stall
  task automatic wait_tx(int target, int stall_test, string what);
    int t;
    t = 0;
    if (!hung) begin
      while (tx_count < target && t < tx_limit) begin
        @(posedge clk_i);
        t++;
        if (stall_test != 0 && s_tready) begin
          flag_error(stall_test, "s_tready high while a frame is held");
        end
      end
      if (stall_test != 0) begin
        chk_cnt[stall_test]++;
      end
      if (tx_count < target) begin
        $display("timeout: no %s on the link", what);
        hung = 1'b1;
      end
    end
  endtask

  task automatic pulse_dllp(bit nak, logic [seq_width-1:0] seq);
    dllp_valid <= 1'b1;
    dllp_nak   <= nak;
    dllp_seq   <= seq;
    @(posedge clk_i);
    dllp_valid <= 1'b0;
  endtask

  // matching ACK, then the write side must open again
  task automatic release_frame();
    int t;
    t = 0;
    if (!hung) begin
      pulse_dllp(1'b0, seq_q[0]);
      while (!s_tready && t < 20) begin
        @(posedge clk_i);
        t++;
      end
      chk_cnt[5]++;
      if (!s_tready) begin
        $display("timeout: s_tready did not return after a matching ACK");
        hung = 1'b1;
      end else begin
        void'(seq_q.pop_front());
      end
    end
  endtask

  task automatic check_replay_gap();
    if (!hung) begin
      chk_cnt[4]++;
      if (last_gap < replay_timeout) begin
        flag_error(4, $sformatf("replay %0d cycles after last beat", last_gap));
      end
    end
  endtask

  initial begin
    int f;
    int i;
    int t;
    int n_tx;
    int mode;
    int tot_chk;
    int tot_err;
    test_name[1] = "reset state";
    test_name[2] = "in-order frames";
    test_name[3] = "NAK replay";
    test_name[4] = "timeout replay";
    test_name[5] = "ACK matching";
    test_name[6] = "cut-through latency";
    s_tdata     = '0;
    s_tkeep     = '0;
    s_tvalid    = 1'b0;
    s_tlast     = 1'b0;
    link_tready = 1'b0;
    dllp_valid  = 1'b0;
    dllp_nak    = 1'b0;
    dllp_seq    = '0;
    next_seq    = '0;
    n_tx        = 0;
    t           = 0;
    @(posedge clk_i);
    while (rst_i && t < 100) begin
      @(posedge clk_i);
      t++;
    end
    if (rst_i) begin
      $display("timeout: reset never released");
      hung = 1'b1;
    end else begin
      chk_cnt[1] += 2;
      if (!s_tready) begin
        flag_error(1, "s_tready low after reset");
      end
      if (link_tvalid) begin
        flag_error(1, "link_tvalid high after reset");
      end
    end
    $display("test 1 %s: %0d checks, %0d errors", test_name[1], chk_cnt[1], err_cnt[1]);

    for (f = 0; f < num_frames && !hung; f++) begin
      build_frame();
      drive_frame();
      // link_tvalid low until tlast is in, up on the cycle after
      if (!hung) begin
        chk_cnt[6] += 2;
        if (link_tvalid) begin
          flag_error(6, "link_tvalid high before tlast was accepted");
        end
        @(posedge clk_i);
        if (!link_tvalid) begin
          flag_error(6, "link_tvalid low one cycle after tlast");
        end
      end
      n_tx++;
      wait_tx(n_tx, 0, "first transmission");
      mode = rand_below(4);
      if (!hung) begin
        case (mode)
          0: repeat (rand_below(8)) @(posedge clk_i);
          1: begin
            // off-by-something seq, never the held one
            pulse_dllp(1'b0, seq_q[0] + 1'b1 + seq_width'(rand_below(4095)));
            repeat (4) @(posedge clk_i);
            chk_cnt[5]++;
            if (s_tready) begin
              flag_error(5, "wrong-sequence ACK released the frame");
            end
            n_tx++;
            wait_tx(n_tx, 5, "replay after wrong ACK");
            check_replay_gap();
          end
          2: begin
            pulse_dllp(1'b1, seq_q[0]);
            n_tx++;
            wait_tx(n_tx, 3, "replay after NAK");
          end
          default: begin
            n_tx++;
            wait_tx(n_tx, 4, "replay after silence");
            check_replay_gap();
          end
        endcase
      end
      release_frame();
    end

    repeat (10) @(posedge clk_i);
    tot_chk = chk_cnt[1];
    tot_err = err_cnt[1];
    for (i = 2; i <= 6; i++) begin
      $display("test %0d %s: %0d checks, %0d errors", i, test_name[i], chk_cnt[i], err_cnt[i]);
      tot_chk += chk_cnt[i];
      tot_err += err_cnt[i];
    end
    $display("frames %0d, checks %0d, errors %0d, timeouts %0d", f, tot_chk, tot_err, hung);
    if (tot_err == 0 && !hung) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_dll_tx

// ==== sim.f ====
source/dll_tx_pkg.sv
source/tlp_seq_stamper.sv
source/axis_retry_fifo.sv
source/dll_tx_sender.sv
source/dll_tx_top.sv
verification/tb_clk_gen.sv
verification/tb_dll_tx.sv
